// ==== rtl/pbch_dmrs_pkg.sv ====
`default_nettype none

package pbch_dmrs_pkg;

    // cell and sample geometry
    localparam int N_ID_W         = 10;
    localparam int SAMPLE_W       = 16;
    localparam int IQ_W           = 32;
    localparam int FFT_LEN        = 256;

    // pilot sequence geometry
    localparam int NUM_CAND       = 8;
    localparam int PILOTS_PER_SYM = 64;
    localparam int LFSR_N         = 31;
    localparam int SKIP_LEN       = 1600;

    // 64 pilots with two bits each give a range of +/-128
    localparam int CORR_W         = 9;

    typedef logic [N_ID_W-1:0] n_id_t;

    // real part sits in the low half, imaginary part in the high half
    typedef logic [IQ_W-1:0] iq_t;

    // high bit is c(2m), low bit is c(2m+1)
    typedef logic [1:0] qpsk_t;
    typedef qpsk_t [NUM_CAND-1:0] qpsk_vec_t;

    typedef logic [$clog2(NUM_CAND)-1:0] ibar_t;
    typedef logic signed [CORR_W-1:0] corr_t;
    typedef logic [$clog2(PILOTS_PER_SYM)-1:0] pilot_idx_t;
    typedef logic [$clog2(FFT_LEN)-1:0] sc_idx_t;

endpackage

`default_nettype wire

// ==== rtl/dmrs_detect_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module dmrs_detect_ctrl (
    input  wire logic                      clk_i,
    input  wire logic                      reset_ni,
    input  wire logic                      n_id_valid_i,
    input  wire pbch_dmrs_pkg::n_id_t      n_id_i,
    input  wire logic                      pbch_start_i,
    input  wire logic                      sample_valid_i,
    output logic                           lfsr_load_o,
    output logic                           lfsr_step_o,
    output logic                           wr_en_o,
    output pbch_dmrs_pkg::pilot_idx_t      wr_idx_o,
    output logic                           wr_odd_o,
    output pbch_dmrs_pkg::pilot_idx_t      rd_idx_o,
    output logic                           pilot_o,
    output logic                           clear_o,
    output logic                           decide_o,
    output logic                           dmrs_ready_o
);

    import pbch_dmrs_pkg::*;

    typedef enum logic [2:0] {GEN_IDLE, GEN_LOAD, GEN_SKIP, GEN_STORE, GEN_DONE} gen_state_t;
    typedef enum logic [1:0] {DET_IDLE, DET_COLLECT, DET_DECIDE} det_state_t;
    typedef logic [$clog2(SKIP_LEN)-1:0] gen_cnt_t;

    gen_state_t gen_state;
    gen_cnt_t   gen_cnt;
    det_state_t det_state;
    sc_idx_t    sc_cnt;
    pilot_idx_t rd_idx;
    logic [1:0] nid_mod4;
    logic       decide_q;
    logic       start_ok;

    // a new cell ID always wins over a PBCH start in the same cycle
    assign start_ok = pbch_start_i && dmrs_ready_o && !n_id_valid_i;

    // generation: one load, SKIP_LEN warm-up steps, then two steps per stored pilot
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            gen_state <= GEN_IDLE;
            gen_cnt   <= '0;
        end else if (n_id_valid_i) begin
            gen_state <= GEN_LOAD;
            gen_cnt   <= '0;
        end else begin
            case (gen_state)
                GEN_LOAD: begin
                    gen_state <= GEN_SKIP;
                    gen_cnt   <= '0;
                end
                GEN_SKIP: begin
                    if (gen_cnt == gen_cnt_t'(SKIP_LEN - 1)) begin
                        gen_state <= GEN_STORE;
                        gen_cnt   <= '0;
                    end else begin
                        gen_cnt <= gen_cnt + 1'b1;
                    end
                end
                GEN_STORE: begin
                    if (gen_cnt == gen_cnt_t'(2 * PILOTS_PER_SYM - 1)) begin
                        gen_state <= GEN_DONE;
                    end
                    gen_cnt <= gen_cnt + 1'b1;
                end
                default: begin
                    gen_state <= gen_state;
                end
            endcase
        end
    end

    assign lfsr_load_o  = (gen_state == GEN_LOAD);
    assign lfsr_step_o  = (gen_state == GEN_SKIP) || (gen_state == GEN_STORE);
    assign wr_en_o      = (gen_state == GEN_STORE);
    assign wr_idx_o     = pilot_idx_t'(gen_cnt >> 1);
    assign wr_odd_o     = gen_cnt[0];
    assign dmrs_ready_o = (gen_state == GEN_DONE);

    // detection: count one symbol of valid samples and step through the pilots
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            det_state <= DET_IDLE;
            sc_cnt    <= '0;
            rd_idx    <= '0;
            nid_mod4  <= '0;
            decide_q  <= 1'b0;
        end else begin
            decide_q <= 1'b0;
            if (n_id_valid_i) begin
                nid_mod4  <= n_id_i[1:0];
                det_state <= DET_IDLE;
            end else begin
                case (det_state)
                    DET_IDLE: begin
                        if (start_ok) begin
                            det_state <= DET_COLLECT;
                            sc_cnt    <= '0;
                            rd_idx    <= '0;
                        end
                    end
                    DET_COLLECT: begin
                        if (sample_valid_i) begin
                            sc_cnt <= sc_cnt + 1'b1;
                            if (pilot_o) begin
                                rd_idx <= rd_idx + 1'b1;
                            end
                            if (sc_cnt == sc_idx_t'(FFT_LEN - 1)) begin
                                det_state <= DET_DECIDE;
                            end
                        end
                    end
                    default: begin
                        // last pilot is still in the correlator input register here
                        decide_q  <= 1'b1;
                        det_state <= DET_IDLE;
                    end
                endcase
            end
        end
    end

    assign pilot_o  = (det_state == DET_COLLECT) && sample_valid_i && (sc_cnt[1:0] == nid_mod4);
    assign rd_idx_o = rd_idx;
    assign clear_o  = (det_state == DET_IDLE) && start_ok;
    assign decide_o = decide_q && !n_id_valid_i;

endmodule

`default_nettype wire

// ==== rtl/gold_seq_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module gold_seq_gen (
    input  wire logic                          clk_i,
    input  wire logic                          reset_ni,
    input  wire pbch_dmrs_pkg::n_id_t          n_id_i,
    input  wire logic                          n_id_valid_i,
    input  wire logic                          load_i,
    input  wire logic                          step_i,
    output logic [pbch_dmrs_pkg::NUM_CAND-1:0] seq_bits_o
);

    import pbch_dmrs_pkg::*;

    logic [LFSR_N-1:0] c_init [NUM_CAND];
    logic [LFSR_N-1:0] x1;
    logic [LFSR_N-1:0] x2 [NUM_CAND];

    // c_init = 2^11 (ibar+1)(floor(N_id/4)+1) + 2^6 (ibar+1) + (N_id mod 4)
    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            for (int i = 0; i < NUM_CAND; i++) begin
                c_init[i] <= ((LFSR_N'(i + 1) * LFSR_N'(n_id_i[N_ID_W-1:2] + 1'b1)) << 11)
                             + (LFSR_N'(i + 1) << 6)
                             + LFSR_N'(n_id_i[1:0]);
            end
        end
    end

    // bit j of each register holds x(n+j), so bit 0 is the current output
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1 <= LFSR_N'(1);
            for (int i = 0; i < NUM_CAND; i++) begin
                x2[i] <= '0;
            end
        end else if (load_i) begin
            x1 <= LFSR_N'(1);
            for (int i = 0; i < NUM_CAND; i++) begin
                x2[i] <= c_init[i];
            end
        end else if (step_i) begin
            // x1(n+31) = x1(n+3) + x1(n)
            x1 <= {x1[3] ^ x1[0], x1[LFSR_N-1:1]};
            for (int i = 0; i < NUM_CAND; i++) begin
                // x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
                x2[i] <= {x2[i][3] ^ x2[i][2] ^ x2[i][1] ^ x2[i][0], x2[i][LFSR_N-1:1]};
            end
        end
    end

    // the x1 half is shared by all candidates
    always_comb begin
        for (int i = 0; i < NUM_CAND; i++) begin
            seq_bits_o[i] = x1[0] ^ x2[i][0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dmrs_pilot_store.sv ====
`default_nettype none
`timescale 1ns/1ps

module dmrs_pilot_store (
    input  wire logic                          clk_i,
    input  wire logic                          wr_en_i,
    input  wire pbch_dmrs_pkg::pilot_idx_t     wr_idx_i,
    input  wire logic                          wr_odd_i,
    input  wire logic [pbch_dmrs_pkg::NUM_CAND-1:0] bits_i,
    input  wire pbch_dmrs_pkg::pilot_idx_t     rd_idx_i,
    output pbch_dmrs_pkg::qpsk_vec_t           pilots_o
);

    import pbch_dmrs_pkg::*;

    qpsk_vec_t             mem [PILOTS_PER_SYM];
    logic [NUM_CAND-1:0]   even_bits;
    qpsk_vec_t             wr_word;

    // the even bit waits here so each pair lands in one full-word write
    always_comb begin
        for (int i = 0; i < NUM_CAND; i++) begin
            wr_word[i] = {even_bits[i], bits_i[i]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            if (wr_odd_i) begin
                mem[wr_idx_i] <= wr_word;
            end else begin
                even_bits <= bits_i;
            end
        end
    end

    // registered read lines up with the sample register in the correlator
    always_ff @(posedge clk_i) begin
        pilots_o <= mem[rd_idx_i];
    end

endmodule

`default_nettype wire

// ==== rtl/dmrs_correlator.sv ====
`default_nettype none
`timescale 1ns/1ps

module dmrs_correlator (
    input  wire logic                                       clk_i,
    input  wire logic                                       reset_ni,
    input  wire pbch_dmrs_pkg::iq_t                         sample_i,
    input  wire logic                                       sample_valid_i,
    input  wire logic                                       pilot_i,
    input  wire logic                                       clear_i,
    input  wire pbch_dmrs_pkg::qpsk_vec_t                   pilots_i,
    output pbch_dmrs_pkg::corr_t [pbch_dmrs_pkg::NUM_CAND-1:0] corr_o,
    output pbch_dmrs_pkg::corr_t [pbch_dmrs_pkg::NUM_CAND-1:0] corr_rot_o
);

    import pbch_dmrs_pkg::*;

    iq_t   sample_r;
    logic  pilot_r;
    qpsk_t demod;
    qpsk_t demod_rot;

    // two bits per pilot, each worth +1 on a match and -1 otherwise
    function automatic corr_t pair_score(input qpsk_t pil_bits, input qpsk_t rx_bits);
        qpsk_t diff;
        diff = pil_bits ^ rx_bits;
        case (diff)
            2'b00:   return corr_t'(2);
            2'b11:   return corr_t'(-2);
            default: return corr_t'(0);
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_r <= sample_i;
        end
    end

    // hard QPSK decision from the sign bits of both halves
    assign demod     = {sample_r[SAMPLE_W-1], sample_r[IQ_W-1]};
    // same decision after a 90 degree turn of the constellation
    assign demod_rot = {~sample_r[IQ_W-1], sample_r[SAMPLE_W-1]};

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pilot_r    <= 1'b0;
            corr_o     <= '0;
            corr_rot_o <= '0;
        end else begin
            pilot_r <= pilot_i;
            if (clear_i) begin
                corr_o     <= '0;
                corr_rot_o <= '0;
            end else if (pilot_r) begin
                for (int i = 0; i < NUM_CAND; i++) begin
                    corr_o[i]     <= corr_o[i] + pair_score(pilots_i[i], demod);
                    corr_rot_o[i] <= corr_rot_o[i] + pair_score(pilots_i[i], demod_rot);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/corr_peak_select.sv ====
`default_nettype none
`timescale 1ns/1ps

module corr_peak_select (
    input  wire logic                                          clk_i,
    input  wire logic                                          reset_ni,
    input  wire pbch_dmrs_pkg::corr_t [pbch_dmrs_pkg::NUM_CAND-1:0] corr_i,
    input  wire pbch_dmrs_pkg::corr_t [pbch_dmrs_pkg::NUM_CAND-1:0] corr_rot_i,
    input  wire logic                                          decide_i,
    output pbch_dmrs_pkg::ibar_t                               ibar_o,
    output logic                                               ibar_valid_o
);

    import pbch_dmrs_pkg::*;

    logic [CORR_W-1:0] mag [NUM_CAND];
    logic [CORR_W-1:0] best_mag;
    ibar_t             best_idx;

    function automatic logic [CORR_W-1:0] abs_corr(input corr_t v);
        return v[CORR_W-1] ? -v : v;
    endfunction

    // a candidate scores with the stronger of its direct and rotated values
    always_comb begin
        for (int i = 0; i < NUM_CAND; i++) begin
            if (abs_corr(corr_rot_i[i]) > abs_corr(corr_i[i])) begin
                mag[i] = abs_corr(corr_rot_i[i]);
            end else begin
                mag[i] = abs_corr(corr_i[i]);
            end
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_mag = mag[0];
        best_idx = '0;
        for (int i = 1; i < NUM_CAND; i++) begin
            if (mag[i] > best_mag) begin
                best_mag = mag[i];
                best_idx = ibar_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (decide_i) begin
            ibar_o <= best_idx;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= decide_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pbch_dmrs_detector.sv ====
`default_nettype none
`timescale 1ns/1ps

module pbch_dmrs_detector (
    input  wire logic                  clk_i,
    input  wire logic                  reset_ni,
    input  wire pbch_dmrs_pkg::n_id_t  n_id_i,
    input  wire logic                  n_id_valid_i,
    input  wire pbch_dmrs_pkg::iq_t    sample_i,
    input  wire logic                  sample_valid_i,
    input  wire logic                  pbch_start_i,
    output logic                       dmrs_ready_o,
    output pbch_dmrs_pkg::ibar_t       ibar_o,
    output logic                       ibar_valid_o
);

    import pbch_dmrs_pkg::*;

    logic                lfsr_load;
    logic                lfsr_step;
    logic [NUM_CAND-1:0] seq_bits;
    logic                wr_en;
    pilot_idx_t          wr_idx;
    logic                wr_odd;
    pilot_idx_t          rd_idx;
    qpsk_vec_t           pilots;
    logic                pilot;
    logic                clear;
    logic                decide;

    corr_t [NUM_CAND-1:0] corr;
    corr_t [NUM_CAND-1:0] corr_rot;

    dmrs_detect_ctrl dmrs_detect_ctrl_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_valid_i   (n_id_valid_i),
        .n_id_i         (n_id_i),
        .pbch_start_i   (pbch_start_i),
        .sample_valid_i (sample_valid_i),
        .lfsr_load_o    (lfsr_load),
        .lfsr_step_o    (lfsr_step),
        .wr_en_o        (wr_en),
        .wr_idx_o       (wr_idx),
        .wr_odd_o       (wr_odd),
        .rd_idx_o       (rd_idx),
        .pilot_o        (pilot),
        .clear_o        (clear),
        .decide_o       (decide),
        .dmrs_ready_o   (dmrs_ready_o)
    );

    gold_seq_gen gold_seq_gen_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .load_i       (lfsr_load),
        .step_i       (lfsr_step),
        .seq_bits_o   (seq_bits)
    );

    dmrs_pilot_store dmrs_pilot_store_inst (
        .clk_i    (clk_i),
        .wr_en_i  (wr_en),
        .wr_idx_i (wr_idx),
        .wr_odd_i (wr_odd),
        .bits_i   (seq_bits),
        .rd_idx_i (rd_idx),
        .pilots_o (pilots)
    );

    dmrs_correlator dmrs_correlator_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pilot_i        (pilot),
        .clear_i        (clear),
        .pilots_i       (pilots),
        .corr_o         (corr),
        .corr_rot_o     (corr_rot)
    );

    corr_peak_select corr_peak_select_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .corr_i       (corr),
        .corr_rot_i   (corr_rot),
        .decide_i     (decide),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_pbch_dmrs_detector.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_pbch_dmrs_detector;

    import pbch_dmrs_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_ENTRIES   = 14;
    localparam int GEN_CYCLES    = 1730;
    localparam int RESULT_CYCLES = 4;
    localparam int ABORT_SAMPLES = 100;
    localparam int PILOT_BITS    = 2 * PILOTS_PER_SYM;
    localparam int SEQ_LEN       = SKIP_LEN + PILOT_BITS;

    // columns are n_id, true ibar, rotate, flipped pilot bits, valid gaps, abort first, expected
    typedef struct packed {
        n_id_t      n_id;
        ibar_t      ibar;
        logic       rotate;
        logic [4:0] flips;
        logic       gaps;
        logic       abort;
        ibar_t      exp_ibar;
    } entry_t;

    logic        clk_i = 1'b0;
    logic        reset_ni;
    n_id_t       n_id_i;
    logic        n_id_valid_i;
    iq_t         sample_i;
    logic        sample_valid_i;
    logic        pbch_start_i;
    logic        dmrs_ready_o;
    ibar_t       ibar_o;
    logic        ibar_valid_o;

    entry_t      entries [NUM_ENTRIES];
    logic [31:0] lcg_state;
    int          pulse_cnt = 0;
    int          pulses_expected = 0;

    pbch_dmrs_detector pbch_dmrs_detector_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_o         (ibar_o),
        .ibar_valid_o   (ibar_valid_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // every cycle with ibar_valid_o high counts as one result
    always @(negedge clk_i) begin
        if (ibar_valid_o) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_ibar(input ibar_t got, input ibar_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("Fail at %0t: ibar_o is %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("Fail at %0t: dmrs_ready_o is %b, expected %b",
                                       $time, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            end_with_failure($sformatf("Fail at %0t: ibar_valid_o pulse count is %0d, expected %0d",
                                       $time, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // c(n) of TS 38.211 for n = 0..127, straight from the recursions
    function automatic logic [PILOT_BITS-1:0] gold_bits(input n_id_t n_id, input int ibar);
        bit                    x1 [SEQ_LEN];
        bit                    x2 [SEQ_LEN];
        logic [LFSR_N-1:0]     c_init;
        logic [PILOT_BITS-1:0] c;
        int                    nid;
        nid = int'(n_id);
        c_init = LFSR_N'(2048 * (ibar + 1) * (nid / 4 + 1) + 64 * (ibar + 1) + nid % 4);
        for (int n = 0; n < LFSR_N; n++) begin
            x1[n] = (n == 0);
            x2[n] = c_init[n];
        end
        for (int n = 0; n < SEQ_LEN - LFSR_N; n++) begin
            x1[n + 31] = x1[n + 3] ^ x1[n];
            x2[n + 31] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
        end
        for (int n = 0; n < PILOT_BITS; n++) begin
            c[n] = x1[n + SKIP_LEN] ^ x2[n + SKIP_LEN];
        end
        return c;
    endfunction

    function automatic logic [PILOT_BITS-1:0] flip_mask(input int count);
        logic [PILOT_BITS-1:0] mask;
        logic [31:0]           r;
        int                    placed;
        mask = '0;
        placed = 0;
        while (placed < count) begin
            r = next_random();
            if (!mask[r[22:16]]) begin
                mask[r[22:16]] = 1'b1;
                placed++;
            end
        end
        return mask;
    endfunction

    function automatic logic [SAMPLE_W-1:0] qpsk_level(input logic neg, input logic [13:0] mag);
        logic [SAMPLE_W-1:0] val;
        val = {2'b00, mag} | 16'd1;
        return neg ? (~val + 16'd1) : val;
    endfunction

    // a set sign bit stands for a pilot bit of one, rotation turns the point by -90 degrees
    function automatic iq_t pilot_sample(input logic b_even, input logic b_odd,
                                         input logic rotate, input logic [31:0] r);
        logic re_neg;
        logic im_neg;
        re_neg = rotate ? b_odd : b_even;
        im_neg = rotate ? ~b_even : b_odd;
        return {qpsk_level(im_neg, r[29:16]), qpsk_level(re_neg, r[13:0])};
    endfunction

    task automatic load_cell(input n_id_t n_id);
        int waited;
        n_id_i = n_id;
        n_id_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_valid_i = 1'b0;
        check_ready(dmrs_ready_o, 1'b0);
        // a start and a full symbol of samples while not ready must be ignored
        pbch_start_i = 1'b1;
        waited = 1;
        while (!dmrs_ready_o) begin
            if (waited >= GEN_CYCLES) begin
                end_with_failure("dmrs_ready_o did not rise within 1730 cycles of a new cell ID");
            end
            sample_valid_i = 1'b1;
            sample_i = next_random();
            @(negedge clk_i);
            pbch_start_i = 1'b0;
            waited++;
        end
        sample_valid_i = 1'b0;
    endtask

    task automatic drive_window(input n_id_t n_id, input int count,
                                input logic [PILOT_BITS-1:0] bits, input logic rotate,
                                input logic gaps);
        logic [31:0] r;
        int          k;
        pbch_start_i = 1'b1;
        @(negedge clk_i);
        pbch_start_i = 1'b0;
        k = 0;
        while (k < count) begin
            check_ready(dmrs_ready_o, 1'b1);
            r = next_random();
            sample_i = r;
            sample_valid_i = !(gaps && r[31:30] == 2'b00);
            if (sample_valid_i) begin
                if (k % 4 == int'(n_id) % 4) begin
                    sample_i = pilot_sample(bits[2 * (k / 4)], bits[2 * (k / 4) + 1], rotate, r);
                end
                k++;
            end
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
    endtask

    task automatic run_entry(input int idx);
        entry_t                e;
        logic [PILOT_BITS-1:0] bits;
        int                    waited;
        e = entries[idx];
        bits = gold_bits(e.n_id, int'(e.ibar)) ^ flip_mask(int'(e.flips));
        if (e.abort) begin
            // the new cell ID lands in the middle of a running window
            drive_window(e.n_id, ABORT_SAMPLES, bits, e.rotate, e.gaps);
        end
        load_cell(e.n_id);
        check_count(pulse_cnt, pulses_expected);
        drive_window(e.n_id, FFT_LEN, bits, e.rotate, e.gaps);
        waited = 0;
        while (!ibar_valid_o) begin
            if (waited >= RESULT_CYCLES) begin
                end_with_failure("no ibar_valid_o pulse after a full detection window");
            end
            @(negedge clk_i);
            waited++;
        end
        check_ibar(ibar_o, e.exp_ibar);
        pulses_expected++;
        repeat (4) @(negedge clk_i);
        check_count(pulse_cnt, pulses_expected);
    endtask

    initial begin
        repeat (RESET_CYCLES + NUM_ENTRIES * 2600) @(posedge clk_i);
        end_with_failure("watchdog expired before the tests finished");
    end

    initial begin
        lcg_state      = 32'd29;
        reset_ni       = 1'b0;
        n_id_i         = '0;
        n_id_valid_i   = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        pbch_start_i   = 1'b0;
        entries[0]  = '{10'd0,    3'd0, 1'b0, 5'd0,  1'b0, 1'b0, 3'd0};
        entries[1]  = '{10'd1,    3'd1, 1'b0, 5'd0,  1'b0, 1'b0, 3'd1};
        entries[2]  = '{10'd2,    3'd2, 1'b0, 5'd0,  1'b0, 1'b0, 3'd2};
        entries[3]  = '{10'd3,    3'd3, 1'b0, 5'd0,  1'b0, 1'b0, 3'd3};
        entries[4]  = '{10'd517,  3'd4, 1'b0, 5'd0,  1'b0, 1'b0, 3'd4};
        entries[5]  = '{10'd1006, 3'd5, 1'b0, 5'd0,  1'b0, 1'b0, 3'd5};
        entries[6]  = '{10'd730,  3'd6, 1'b0, 5'd0,  1'b0, 1'b0, 3'd6};
        entries[7]  = '{10'd1007, 3'd7, 1'b0, 5'd0,  1'b0, 1'b0, 3'd7};
        entries[8]  = '{10'd12,   3'd2, 1'b1, 5'd0,  1'b0, 1'b0, 3'd2};
        entries[9]  = '{10'd301,  3'd6, 1'b1, 5'd0,  1'b0, 1'b0, 3'd6};
        entries[10] = '{10'd88,   3'd5, 1'b0, 5'd20, 1'b1, 1'b0, 3'd5};
        entries[11] = '{10'd777,  3'd1, 1'b1, 5'd14, 1'b1, 1'b0, 3'd1};
        entries[12] = '{10'd455,  3'd3, 1'b0, 5'd0,  1'b0, 1'b1, 3'd3};
        entries[13] = '{10'd902,  3'd0, 1'b1, 5'd8,  1'b1, 1'b1, 3'd0};
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_ni = 1'b1;
        check_ready(dmrs_ready_o, 1'b0);
        check_count(pulse_cnt, 0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/pbch_dmrs_pkg.sv
rtl/dmrs_detect_ctrl.sv
rtl/gold_seq_gen.sv
rtl/dmrs_pilot_store.sv
rtl/dmrs_correlator.sv
rtl/corr_peak_select.sv
rtl/pbch_dmrs_detector.sv
dv/tb_pbch_dmrs_detector.sv

// ==== Makefile ====
TB_TOP = tb_pbch_dmrs_detector

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module pbch_dmrs_detector

sim:
	verilator --binary --timing -f sources.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP)

clean:
	rm -rf obj_dir
